//--- ctrl_map_pkg.sv
package ctrl_map_pkg;

    // host port as seen from the BRAM controller
    localparam int HOST_DATA_W = 32;
    localparam int HOST_ADDR_W = 16;

    // register index sits in byte address bits 11:5, 32 bytes per register
    localparam int REG_ADDR_LSB = 5;
    localparam int REG_ADDR_W   = 7;

    typedef enum logic [REG_ADDR_W-1:0] {
        REG_TLB        = 7'h02,
        REG_PARAMS     = 7'h04,
        REG_DMA_READS  = 7'h0A,
        REG_DMA_WRITES = 7'h0B,
        REG_STATS      = 7'h0D
    } reg_sel_e;

    // tlb command, last word only contributes bit 0
    localparam int TLB_WORDS = 5;
    localparam int TLB_CMD_W = 129;

    // training parameter block
    localparam int PARAM_WORDS = 15;
    localparam int PARAM_W     = 480;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DECODE,
        WR_STREAM_WAIT
    } write_state_e;

    typedef enum logic {
        RD_IDLE,
        RD_RESPOND
    } read_state_e;

endpackage

//--- stat_map_pkg.sv
package stat_map_pkg;

    // width of one event counter
    localparam int STAT_W = 32;

    // byte length counters, read back in two halves
    localparam int LEN_W = 48;

    localparam int NUM_STATS = 10;

    // rotation order of the statistics register
    typedef enum logic [3:0] {
        STAT_WR_CMD,
        STAT_WR_WORD,
        STAT_WR_PKG,
        STAT_WR_LEN,
        STAT_RD_CMD,
        STAT_RD_WORD,
        STAT_RD_PKG,
        STAT_RD_LEN,
        STAT_TLB_MISS,
        STAT_TLB_CROSS
    } stat_sel_e;

    // returned for any register without a read function
    localparam logic [STAT_W-1:0] UNMAPPED_READ = 32'hdeadbeef;

endpackage

//--- reg_write_fsm.sv
`timescale 1ns/1ps

module reg_write_fsm
    import ctrl_map_pkg::*;
(
    input  logic                   user_clk,
    input  logic                   user_aresetn,
    input  logic                   bram_en,
    input  logic [3:0]             bram_we,
    input  logic [HOST_ADDR_W-1:0] bram_addr,
    input  logic [HOST_DATA_W-1:0] bram_wrdata,
    input  logic                   tlb_busy,
    input  logic                   param_busy,
    output logic                   tlb_word_strobe,
    output logic                   param_word_strobe,
    output logic [HOST_DATA_W-1:0] word_data,
    output logic                   reset_dma_read_length,
    output logic                   reset_dma_write_length
);

    write_state_e           wr_state;
    logic [REG_ADDR_W-1:0]  wr_idx;
    logic [HOST_DATA_W-1:0] wr_data;
    logic                   host_wr;
    logic                   is_stream_reg;
    logic                   target_busy;

    assign host_wr = bram_en && bram_we[0];

    assign is_stream_reg = (wr_idx == REG_TLB) || (wr_idx == REG_PARAMS);

    // busy of whichever assembler the last write went to
    assign target_busy = (wr_idx == REG_TLB) ? tlb_busy : param_busy;

    always_ff @(posedge user_clk) begin
        if (!user_aresetn) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (host_wr) begin
                        wr_state <= WR_DECODE;
                    end
                end
                WR_DECODE: begin
                    if (is_stream_reg) begin
                        wr_state <= WR_STREAM_WAIT;
                    end else begin
                        wr_state <= WR_IDLE;
                    end
                end
                WR_STREAM_WAIT: begin
                    // stays here while a finished record waits for ready
                    if (!target_busy) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: begin
                    wr_state <= WR_IDLE;
                end
            endcase
        end
    end

    // host access is only taken while idle
    always_ff @(posedge user_clk) begin
        if (wr_state == WR_IDLE && host_wr) begin
            wr_idx  <= bram_addr[REG_ADDR_LSB +: REG_ADDR_W];
            wr_data <= bram_wrdata;
        end
    end

    assign word_data         = wr_data;
    assign tlb_word_strobe   = (wr_state == WR_DECODE) && (wr_idx == REG_TLB);
    assign param_word_strobe = (wr_state == WR_DECODE) && (wr_idx == REG_PARAMS);

    // one cycle pulse right after the decode edge
    always_ff @(posedge user_clk) begin
        if (!user_aresetn) begin
            reset_dma_read_length  <= 1'b0;
            reset_dma_write_length <= 1'b0;
        end else begin
            reset_dma_read_length  <= (wr_state == WR_DECODE) && (wr_idx == REG_DMA_READS);
            reset_dma_write_length <= (wr_state == WR_DECODE) && (wr_idx == REG_DMA_WRITES);
        end
    end

    a_single_len_reset: assert property (
        @(posedge user_clk) disable iff (!user_aresetn)
        !(reset_dma_read_length && reset_dma_write_length)
    );

endmodule

//--- stream_word_assembler.sv
`timescale 1ns/1ps

module stream_word_assembler
    import ctrl_map_pkg::*;
#(
    parameter int NUM_WORDS = 5,
    parameter int OUT_W     = 129
) (
    input  logic                   user_clk,
    input  logic                   user_aresetn,
    input  logic                   word_strobe,
    input  logic [HOST_DATA_W-1:0] word_data,
    input  logic                   ready,
    output logic                   busy,
    output logic                   valid,
    output logic [OUT_W-1:0]       data
);

    localparam int CNT_W = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;

    logic [CNT_W-1:0] word_cnt;
    logic             last_word;
    logic             take_word;

    assign take_word = word_strobe && !busy;
    assign last_word = (word_cnt == CNT_W'(NUM_WORDS - 1));

    always_ff @(posedge user_clk) begin
        if (!user_aresetn) begin
            word_cnt <= '0;
        end else if (take_word) begin
            if (last_word) begin
                word_cnt <= '0;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // word k lands at bit 32k, anything past OUT_W is dropped
    always_ff @(posedge user_clk) begin
        if (take_word) begin
            for (int b = 0; b < OUT_W; b++) begin
                if (b / HOST_DATA_W == int'(word_cnt)) begin
                    data[b] <= word_data[b % HOST_DATA_W];
                end
            end
        end
    end

    // busy from last word to handshake, valid one edge after busy
    always_ff @(posedge user_clk) begin
        if (!user_aresetn) begin
            busy  <= 1'b0;
            valid <= 1'b0;
        end else begin
            if (valid && ready) begin
                busy  <= 1'b0;
                valid <= 1'b0;
            end else if (busy) begin
                valid <= 1'b1;
            end else if (take_word && last_word) begin
                busy <= 1'b1;
            end
        end
    end

    a_hold_under_backpressure: assert property (
        @(posedge user_clk) disable iff (!user_aresetn)
        (valid && !ready) |=> (valid && $stable(data))
    );

endmodule

//--- reg_read_mux.sv
`timescale 1ns/1ps

module reg_read_mux
    import ctrl_map_pkg::*;
    import stat_map_pkg::*;
(
    input  logic                   user_clk,
    input  logic                   user_aresetn,
    input  logic                   bram_en,
    input  logic [3:0]             bram_we,
    input  logic [HOST_ADDR_W-1:0] bram_addr,
    input  logic [STAT_W-1:0]      dma_write_cmd_counter,
    input  logic [STAT_W-1:0]      dma_write_word_counter,
    input  logic [STAT_W-1:0]      dma_write_pkg_counter,
    input  logic [STAT_W-1:0]      dma_read_cmd_counter,
    input  logic [STAT_W-1:0]      dma_read_word_counter,
    input  logic [STAT_W-1:0]      dma_read_pkg_counter,
    input  logic [STAT_W-1:0]      tlb_miss_counter,
    input  logic [STAT_W-1:0]      tlb_boundary_crossing_counter,
    input  logic [LEN_W-1:0]       dma_write_length_counter,
    input  logic [LEN_W-1:0]       dma_read_length_counter,
    input  logic                   dma_reads_flushed,
    output logic [HOST_DATA_W-1:0] bram_rddata
);

    localparam int PAD_W = 2 * HOST_DATA_W - LEN_W;

    read_state_e            rd_state;
    logic [REG_ADDR_W-1:0]  rd_idx;
    stat_sel_e              stat_idx;
    logic                   rd_upper;
    logic                   wr_upper;
    logic [HOST_DATA_W-1:0] stat_val;
    logic [HOST_DATA_W-1:0] resp_mux;
    logic [HOST_DATA_W-1:0] rd_resp;
    logic                   rd_resp_vld;

    always_comb begin
        case (stat_idx)
            STAT_WR_CMD:    stat_val = dma_write_cmd_counter;
            STAT_WR_WORD:   stat_val = dma_write_word_counter;
            STAT_WR_PKG:    stat_val = dma_write_pkg_counter;
            STAT_WR_LEN:    stat_val = dma_write_length_counter[HOST_DATA_W-1:0];
            STAT_RD_CMD:    stat_val = dma_read_cmd_counter;
            STAT_RD_WORD:   stat_val = dma_read_word_counter;
            STAT_RD_PKG:    stat_val = dma_read_pkg_counter;
            STAT_RD_LEN:    stat_val = dma_read_length_counter[HOST_DATA_W-1:0];
            STAT_TLB_MISS:  stat_val = tlb_miss_counter;
            STAT_TLB_CROSS: stat_val = tlb_boundary_crossing_counter;
            default:        stat_val = '0;
        endcase
    end

    always_comb begin
        case (rd_idx)
            REG_DMA_READS: begin
                // length is only meaningful once reads are flushed
                if (!dma_reads_flushed) begin
                    resp_mux = '0;
                end else if (rd_upper) begin
                    resp_mux = {{PAD_W{1'b0}}, dma_read_length_counter[LEN_W-1:HOST_DATA_W]};
                end else begin
                    resp_mux = dma_read_length_counter[HOST_DATA_W-1:0];
                end
            end
            REG_DMA_WRITES: begin
                if (wr_upper) begin
                    resp_mux = {{PAD_W{1'b0}}, dma_write_length_counter[LEN_W-1:HOST_DATA_W]};
                end else begin
                    resp_mux = dma_write_length_counter[HOST_DATA_W-1:0];
                end
            end
            REG_STATS: resp_mux = stat_val;
            default:   resp_mux = UNMAPPED_READ;
        endcase
    end

    always_ff @(posedge user_clk) begin
        if (!user_aresetn) begin
            rd_state    <= RD_IDLE;
            stat_idx    <= STAT_WR_CMD;
            rd_upper    <= 1'b0;
            wr_upper    <= 1'b0;
            rd_resp_vld <= 1'b0;
        end else begin
            rd_resp_vld <= 1'b0;
            case (rd_state)
                RD_IDLE: begin
                    if (bram_en && !bram_we[0]) begin
                        rd_state <= RD_RESPOND;
                    end
                end
                RD_RESPOND: begin
                    rd_resp_vld <= 1'b1;
                    if (rd_idx == REG_DMA_READS) begin
                        rd_upper <= ~rd_upper;
                    end
                    if (rd_idx == REG_DMA_WRITES) begin
                        wr_upper <= ~wr_upper;
                    end
                    if (rd_idx == REG_STATS) begin
                        if (stat_idx == STAT_TLB_CROSS) begin
                            stat_idx <= STAT_WR_CMD;
                        end else begin
                            stat_idx <= stat_sel_e'(stat_idx + 1'b1);
                        end
                    end
                    rd_state <= RD_IDLE;
                end
                default: begin
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge user_clk) begin
        if (rd_state == RD_IDLE && bram_en && !bram_we[0]) begin
            rd_idx <= bram_addr[REG_ADDR_LSB +: REG_ADDR_W];
        end
        if (rd_state == RD_RESPOND) begin
            rd_resp <= resp_mux;
        end
    end

    // second stage, value holds until the next read lands
    always_ff @(posedge user_clk) begin
        if (!user_aresetn) begin
            bram_rddata <= '0;
        end else if (rd_resp_vld) begin
            bram_rddata <= rd_resp;
        end
    end

    a_stat_idx_range: assert property (
        @(posedge user_clk) disable iff (!user_aresetn)
        int'(stat_idx) < NUM_STATS
    );

endmodule

//--- dma_ctrl_regs.sv
`timescale 1ns/1ps

module dma_ctrl_regs
    import ctrl_map_pkg::*;
    import stat_map_pkg::*;
#(
    parameter int TLB_WORDS   = ctrl_map_pkg::TLB_WORDS,
    parameter int TLB_CMD_W   = ctrl_map_pkg::TLB_CMD_W,
    parameter int PARAM_WORDS = ctrl_map_pkg::PARAM_WORDS,
    parameter int PARAM_W     = ctrl_map_pkg::PARAM_W
) (
    input  logic                   user_clk,
    input  logic                   user_aresetn,
    // host port from the BRAM controller
    input  logic                   bram_en,
    input  logic [3:0]             bram_we,
    input  logic [HOST_ADDR_W-1:0] bram_addr,
    input  logic [HOST_DATA_W-1:0] bram_wrdata,
    output logic [HOST_DATA_W-1:0] bram_rddata,
    // tlb command stream
    output logic                   tlb_cmd_valid,
    input  logic                   tlb_cmd_ready,
    output logic [TLB_CMD_W-1:0]   tlb_cmd_data,
    // parameter block stream
    output logic                   param_valid,
    input  logic                   param_ready,
    output logic [PARAM_W-1:0]     param_data,
    // dma and tlb statistics
    input  logic [STAT_W-1:0]      dma_write_cmd_counter,
    input  logic [STAT_W-1:0]      dma_write_word_counter,
    input  logic [STAT_W-1:0]      dma_write_pkg_counter,
    input  logic [STAT_W-1:0]      dma_read_cmd_counter,
    input  logic [STAT_W-1:0]      dma_read_word_counter,
    input  logic [STAT_W-1:0]      dma_read_pkg_counter,
    input  logic [STAT_W-1:0]      tlb_miss_counter,
    input  logic [STAT_W-1:0]      tlb_boundary_crossing_counter,
    input  logic [LEN_W-1:0]       dma_write_length_counter,
    input  logic [LEN_W-1:0]       dma_read_length_counter,
    input  logic                   dma_reads_flushed,
    output logic                   reset_dma_write_length,
    output logic                   reset_dma_read_length
);

    logic                   tlb_word_strobe;
    logic                   param_word_strobe;
    logic [HOST_DATA_W-1:0] word_data;
    logic                   tlb_busy;
    logic                   param_busy;

    reg_write_fsm u_write_fsm (
        .user_clk               (user_clk),
        .user_aresetn           (user_aresetn),
        .bram_en                (bram_en),
        .bram_we                (bram_we),
        .bram_addr              (bram_addr),
        .bram_wrdata            (bram_wrdata),
        .tlb_busy               (tlb_busy),
        .param_busy             (param_busy),
        .tlb_word_strobe        (tlb_word_strobe),
        .param_word_strobe      (param_word_strobe),
        .word_data              (word_data),
        .reset_dma_read_length  (reset_dma_read_length),
        .reset_dma_write_length (reset_dma_write_length)
    );

    stream_word_assembler #(
        .NUM_WORDS (TLB_WORDS),
        .OUT_W     (TLB_CMD_W)
    ) u_tlb_asm (
        .user_clk     (user_clk),
        .user_aresetn (user_aresetn),
        .word_strobe  (tlb_word_strobe),
        .word_data    (word_data),
        .ready        (tlb_cmd_ready),
        .busy         (tlb_busy),
        .valid        (tlb_cmd_valid),
        .data         (tlb_cmd_data)
    );

    stream_word_assembler #(
        .NUM_WORDS (PARAM_WORDS),
        .OUT_W     (PARAM_W)
    ) u_param_asm (
        .user_clk     (user_clk),
        .user_aresetn (user_aresetn),
        .word_strobe  (param_word_strobe),
        .word_data    (word_data),
        .ready        (param_ready),
        .busy         (param_busy),
        .valid        (param_valid),
        .data         (param_data)
    );

    reg_read_mux u_read_mux (
        .user_clk                      (user_clk),
        .user_aresetn                  (user_aresetn),
        .bram_en                       (bram_en),
        .bram_we                       (bram_we),
        .bram_addr                     (bram_addr),
        .dma_write_cmd_counter         (dma_write_cmd_counter),
        .dma_write_word_counter        (dma_write_word_counter),
        .dma_write_pkg_counter         (dma_write_pkg_counter),
        .dma_read_cmd_counter          (dma_read_cmd_counter),
        .dma_read_word_counter         (dma_read_word_counter),
        .dma_read_pkg_counter          (dma_read_pkg_counter),
        .tlb_miss_counter              (tlb_miss_counter),
        .tlb_boundary_crossing_counter (tlb_boundary_crossing_counter),
        .dma_write_length_counter      (dma_write_length_counter),
        .dma_read_length_counter       (dma_read_length_counter),
        .dma_reads_flushed             (dma_reads_flushed),
        .bram_rddata                   (bram_rddata)
    );

endmodule

//--- tb_dma_ctrl_regs.sv
`timescale 1ns/1ps

module tb_dma_ctrl_regs
    import ctrl_map_pkg::*;
    import stat_map_pkg::*;
();

    // enough for about 80 host accesses plus the stream waits
    localparam int CYCLE_LIMIT = 2000;

    logic                   user_clk = 1'b0;
    logic                   user_aresetn;
    logic                   bram_en;
    logic [3:0]             bram_we;
    logic [HOST_ADDR_W-1:0] bram_addr;
    logic [HOST_DATA_W-1:0] bram_wrdata;
    logic [HOST_DATA_W-1:0] bram_rddata;
    logic                   tlb_cmd_valid;
    logic                   tlb_cmd_ready;
    logic [TLB_CMD_W-1:0]   tlb_cmd_data;
    logic                   param_valid;
    logic                   param_ready;
    logic [PARAM_W-1:0]     param_data;
    logic [STAT_W-1:0]      dma_write_cmd_counter;
    logic [STAT_W-1:0]      dma_write_word_counter;
    logic [STAT_W-1:0]      dma_write_pkg_counter;
    logic [STAT_W-1:0]      dma_read_cmd_counter;
    logic [STAT_W-1:0]      dma_read_word_counter;
    logic [STAT_W-1:0]      dma_read_pkg_counter;
    logic [STAT_W-1:0]      tlb_miss_counter;
    logic [STAT_W-1:0]      tlb_boundary_crossing_counter;
    logic [LEN_W-1:0]       dma_write_length_counter;
    logic [LEN_W-1:0]       dma_read_length_counter;
    logic                   dma_reads_flushed;
    logic                   reset_dma_write_length;
    logic                   reset_dma_read_length;

    // testbench view of the stream outputs one cycle back
    logic                   tlb_valid_q = 1'b0;
    logic [TLB_CMD_W-1:0]   tlb_data_q;
    logic                   param_valid_q = 1'b0;
    logic [PARAM_W-1:0]     param_data_q;
    int                     tlb_transfers = 0;
    int                     param_transfers = 0;
    int                     rd_len_high = 0;
    int                     wr_len_high = 0;

    // own model of the read side state
    logic                   rd_half_hi = 1'b0;
    logic                   wr_half_hi = 1'b0;
    int                     stat_pos = 0;

    logic [31:0]            lfsr_state = 32'hc28d;
    int                     cycle_count = 0;

    dma_ctrl_regs DUT (.*);

    initial begin
        forever #50 user_clk = ~user_clk;
    end

    always @(posedge user_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles before all tests finished", cycle_count);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [511:0] got,
                               input logic [511:0] expected);
        if (got !== expected) begin
            $display("FAILED %s got 0x%0h expected 0x%0h", name, got, expected);
            $display("Something failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // expected read data, from the register map rules
    function automatic logic [31:0] expected_read(input logic [REG_ADDR_W-1:0] idx);
        logic [31:0] stats [NUM_STATS];
        logic [31:0] result;
        stats[0] = dma_write_cmd_counter;
        stats[1] = dma_write_word_counter;
        stats[2] = dma_write_pkg_counter;
        stats[3] = dma_write_length_counter[31:0];
        stats[4] = dma_read_cmd_counter;
        stats[5] = dma_read_word_counter;
        stats[6] = dma_read_pkg_counter;
        stats[7] = dma_read_length_counter[31:0];
        stats[8] = tlb_miss_counter;
        stats[9] = tlb_boundary_crossing_counter;
        if (idx == REG_DMA_READS) begin
            if (!dma_reads_flushed) begin
                result = 32'h0;
            end else begin
                result = rd_half_hi ? {16'h0, dma_read_length_counter[47:32]}
                                    : dma_read_length_counter[31:0];
            end
        end else if (idx == REG_DMA_WRITES) begin
            result = wr_half_hi ? {16'h0, dma_write_length_counter[47:32]}
                                : dma_write_length_counter[31:0];
        end else if (idx == REG_STATS) begin
            result = stats[stat_pos];
        end else begin
            result = UNMAPPED_READ;
        end
        return result;
    endfunction

    // one clock step, sampled on the falling edge before new inputs go out
    task automatic next_cycle();
        @(negedge user_clk);
        // ready still holds the value the last rising edge used
        if (tlb_valid_q && tlb_cmd_ready) begin
            tlb_transfers++;
        end else if (tlb_valid_q) begin
            check_value("tlb_cmd_valid", tlb_cmd_valid, 1'b1);
            check_value("tlb_cmd_data", tlb_cmd_data, tlb_data_q);
        end
        if (param_valid_q && param_ready) begin
            param_transfers++;
        end else if (param_valid_q) begin
            check_value("param_valid", param_valid, 1'b1);
            check_value("param_data", param_data, param_data_q);
        end
        if (reset_dma_read_length) begin
            rd_len_high++;
        end
        if (reset_dma_write_length) begin
            wr_len_high++;
        end
        tlb_valid_q   = tlb_cmd_valid;
        tlb_data_q    = tlb_cmd_data;
        param_valid_q = param_valid;
        param_data_q  = param_data;
    endtask

    // one access cycle then four idle cycles
    task automatic host_access(input logic is_write, input logic [REG_ADDR_W-1:0] idx,
                               input logic [31:0] wdata);
        bram_en     = 1'b1;
        bram_we     = is_write ? 4'hf : 4'h0;
        // random byte offset inside the 32 byte register window
        bram_addr   = {4'h0, idx, 5'(random_bits(5))};
        bram_wrdata = wdata;
        next_cycle();
        bram_en     = 1'b0;
        bram_we     = 4'h0;
        bram_addr   = '0;
        bram_wrdata = '0;
        repeat (4) next_cycle();
    endtask

    task automatic read_and_check(input logic [REG_ADDR_W-1:0] idx);
        logic [31:0] expected;
        expected = expected_read(idx);
        host_access(1'b0, idx, 32'h0);
        check_value("bram_rddata", bram_rddata, expected);
        if (idx == REG_DMA_READS) begin
            rd_half_hi = !rd_half_hi;
        end
        if (idx == REG_DMA_WRITES) begin
            wr_half_hi = !wr_half_hi;
        end
        if (idx == REG_STATS) begin
            stat_pos = (stat_pos + 1) % NUM_STATS;
        end
    endtask

    task automatic randomize_counters();
        dma_write_cmd_counter         = 32'(random_bits(32));
        dma_write_word_counter        = 32'(random_bits(32));
        dma_write_pkg_counter         = 32'(random_bits(32));
        dma_read_cmd_counter          = 32'(random_bits(32));
        dma_read_word_counter         = 32'(random_bits(32));
        dma_read_pkg_counter          = 32'(random_bits(32));
        tlb_miss_counter              = 32'(random_bits(32));
        tlb_boundary_crossing_counter = 32'(random_bits(32));
        dma_write_length_counter      = 48'(random_bits(48));
        dma_read_length_counter       = 48'(random_bits(48));
        dma_reads_flushed             = random_bits(1) != 0;
    endtask

    // waits for the record, holds ready low for a random gap, then takes it
    task automatic await_record(input logic use_tlb, input logic [PARAM_W-1:0] expected);
        int gap;
        int start;
        gap   = int'(random_bits(4));
        start = use_tlb ? tlb_transfers : param_transfers;
        while (!(use_tlb ? tlb_cmd_valid : param_valid)) begin
            next_cycle();
        end
        if (use_tlb) begin
            check_value("tlb_cmd_data", tlb_cmd_data, expected);
        end else begin
            check_value("param_data", param_data, expected);
        end
        repeat (gap) next_cycle();
        // ready stays up a second cycle so a valid that lingers would count twice
        tlb_cmd_ready = use_tlb;
        param_ready   = !use_tlb;
        repeat (2) next_cycle();
        tlb_cmd_ready = 1'b0;
        param_ready   = 1'b0;
        check_value("stream transfers", (use_tlb ? tlb_transfers : param_transfers) - start, 1);
        check_value("tlb_cmd_valid", tlb_cmd_valid, 1'b0);
        check_value("param_valid", param_valid, 1'b0);
    endtask

    task automatic tlb_command_test();
        logic [31:0]          words [TLB_WORDS];
        logic [TLB_CMD_W-1:0] expected;
        for (int k = 0; k < TLB_WORDS; k++) begin
            words[k] = 32'(random_bits(32));
            check_value("tlb_cmd_valid", tlb_cmd_valid, 1'b0);
            host_access(1'b1, REG_TLB, words[k]);
        end
        // only bit 0 of the fifth word is used
        expected = {words[4][0], words[3], words[2], words[1], words[0]};
        await_record(1'b1, expected);
    endtask

    task automatic param_block_test();
        logic [31:0]        words [PARAM_WORDS];
        logic [PARAM_W-1:0] expected;
        for (int k = 0; k < PARAM_WORDS; k++) begin
            words[k] = 32'(random_bits(32));
            expected[32*k +: 32] = words[k];
            check_value("param_valid", param_valid, 1'b0);
            host_access(1'b1, REG_PARAMS, words[k]);
        end
        await_record(1'b0, expected);
    endtask

    task automatic length_test();
        int rd_before;
        int wr_before;
        for (int i = 0; i < 8; i++) begin
            randomize_counters();
            // first pair gated off, second pair open, rest random
            if (i < 2) begin
                dma_reads_flushed = (i == 1);
            end
            read_and_check(REG_DMA_READS);
            read_and_check(REG_DMA_WRITES);
        end
        rd_before = rd_len_high;
        wr_before = wr_len_high;
        host_access(1'b1, REG_DMA_READS, 32'(random_bits(32)));
        check_value("reset_dma_read_length cycles", rd_len_high - rd_before, 1);
        check_value("reset_dma_write_length cycles", wr_len_high - wr_before, 0);
        host_access(1'b1, REG_DMA_WRITES, 32'(random_bits(32)));
        check_value("reset_dma_read_length cycles", rd_len_high - rd_before, 1);
        check_value("reset_dma_write_length cycles", wr_len_high - wr_before, 1);
    endtask

    task automatic unmapped_test();
        int rd_before;
        int wr_before;
        rd_before = rd_len_high;
        wr_before = wr_len_high;
        read_and_check(7'h33);
        host_access(1'b1, 7'h07, 32'(random_bits(32)));
        check_value("tlb_cmd_valid", tlb_cmd_valid, 1'b0);
        check_value("param_valid", param_valid, 1'b0);
        check_value("reset_dma_read_length cycles", rd_len_high - rd_before, 0);
        check_value("reset_dma_write_length cycles", wr_len_high - wr_before, 0);
    endtask

    initial begin
        user_aresetn  = 1'b0;
        bram_en       = 1'b0;
        bram_we       = 4'h0;
        bram_addr     = '0;
        bram_wrdata   = '0;
        tlb_cmd_ready = 1'b0;
        param_ready   = 1'b0;
        randomize_counters();
        repeat (3) next_cycle();
        user_aresetn = 1'b1;

        check_value("tlb_cmd_valid", tlb_cmd_valid, 1'b0);
        check_value("param_valid", param_valid, 1'b0);
        check_value("reset_dma_read_length", reset_dma_read_length, 1'b0);
        check_value("reset_dma_write_length", reset_dma_write_length, 1'b0);
        check_value("bram_rddata", bram_rddata, 32'h0);
        next_cycle();

        tlb_command_test();
        param_block_test();
        tlb_command_test();
        param_block_test();
        length_test();

        // ten counters in order, then wrap to the first two
        randomize_counters();
        repeat (12) read_and_check(REG_STATS);

        unmapped_test();

        $display("Everything OK");
        $finish;
    end

endmodule

//--- dma_ctrl_regs.f
ctrl_map_pkg.sv
stat_map_pkg.sv
reg_write_fsm.sv
stream_word_assembler.sv
reg_read_mux.sv
dma_ctrl_regs.sv
tb_dma_ctrl_regs.sv
